/* fu_pkg.sv */
`default_nettype none

package fu_pkg;

    typedef logic [31:0] data_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  robn_t;
    typedef logic [5:0]  prn_t;

    // travels with every result to the result bus
    typedef struct packed {
        robn_t robn;
        prn_t  prn;
    } fu_tag_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'h0,
        ALU_SUB  = 4'h1,
        ALU_AND  = 4'h2,
        ALU_OR   = 4'h3,
        ALU_XOR  = 4'h4,
        ALU_SLT  = 4'h5,
        ALU_SLTU = 4'h6,
        ALU_SLL  = 4'h7,
        ALU_SRL  = 4'h8,
        ALU_SRA  = 4'h9
    } alu_func_t;

    typedef enum logic [1:0] {
        MULT_MUL    = 2'h0, // low word
        MULT_MULH   = 2'h1, // signed x signed, high word
        MULT_MULHSU = 2'h2, // signed x unsigned
        MULT_MULHU  = 2'h3
    } mult_func_t;

    typedef enum logic [1:0] {
        OPA_IS_RS1  = 2'h0,
        OPA_IS_PC   = 2'h1,
        OPA_IS_ZERO = 2'h2
    } opa_sel_t;

    typedef enum logic [2:0] {
        OPB_IS_RS2   = 3'h0,
        OPB_IS_I_IMM = 3'h1,
        OPB_IS_S_IMM = 3'h2,
        OPB_IS_B_IMM = 3'h3,
        OPB_IS_U_IMM = 3'h4,
        OPB_IS_J_IMM = 3'h5
    } opb_sel_t;

    // fillers that stand out in waves
    localparam data_t OPA_BAD = 32'hdead_face;
    localparam data_t OPB_BAD = 32'hface_feed;
    localparam data_t ALU_BAD = 32'hface_beec;

endpackage

`default_nettype wire

/* mult_step_if.sv */
`timescale 1ns/1ps
`default_nettype none

// step handshake inside the multiplier
interface mult_step_if;

    logic load;   // capture operands, clear count
    logic step;   // one shift-add step
    logic finish; // register final word
    logic last;   // final step in progress

    modport ctrl (
        output load, step, finish,
        input  last
    );

    modport counter (
        input  load, step,
        output last
    );

    modport datapath (
        input load, step, finish
    );

endinterface

`default_nettype wire

/* alu_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
    input  wire logic              valid,
    input  wire fu_pkg::inst_t     inst,
    input  wire fu_pkg::data_t     pc,
    input  wire fu_pkg::data_t     op1,
    input  wire fu_pkg::data_t     op2,
    input  wire fu_pkg::alu_func_t func,
    input  wire fu_pkg::opa_sel_t  opa_sel,
    input  wire fu_pkg::opb_sel_t  opb_sel,
    input  wire logic              cond_branch,
    input  wire logic              uncond_branch,
    input  wire fu_pkg::fu_tag_t   tag,
    output logic                   done,
    output fu_pkg::data_t          result,
    output logic                   take_branch,
    output fu_pkg::fu_tag_t        tag_out
);

    fu_pkg::data_t      opa, opb;
    logic signed [31:0] opa_s, opb_s, rs1_s, rs2_s;
    logic               cmp_true;

    assign opa_s = opa;
    assign opb_s = opb;
    assign rs1_s = op1;
    assign rs2_s = op2;

    always_comb begin
        case (opa_sel)
            fu_pkg::OPA_IS_RS1:  opa = op1;
            fu_pkg::OPA_IS_PC:   opa = pc;
            fu_pkg::OPA_IS_ZERO: opa = '0;
            default:             opa = fu_pkg::OPA_BAD;
        endcase
    end

    // sign bit of every RV32 immediate is inst[31]
    always_comb begin
        case (opb_sel)
            fu_pkg::OPB_IS_RS2:   opb = op2;
            fu_pkg::OPB_IS_I_IMM: opb = {{21{inst[31]}}, inst[30:20]};
            fu_pkg::OPB_IS_S_IMM: opb = {{21{inst[31]}}, inst[30:25], inst[11:7]};
            fu_pkg::OPB_IS_B_IMM: opb = {{20{inst[31]}}, inst[7], inst[30:25],
                                         inst[11:8], 1'b0};
            fu_pkg::OPB_IS_U_IMM: opb = {inst[31:12], 12'b0};
            fu_pkg::OPB_IS_J_IMM: opb = {{12{inst[31]}}, inst[19:12], inst[20],
                                         inst[30:21], 1'b0};
            default:              opb = fu_pkg::OPB_BAD;
        endcase
    end

    always_comb begin
        case (func)
            fu_pkg::ALU_ADD:  result = opa + opb;
            fu_pkg::ALU_SUB:  result = opa - opb;
            fu_pkg::ALU_AND:  result = opa & opb;
            fu_pkg::ALU_OR:   result = opa | opb;
            fu_pkg::ALU_XOR:  result = opa ^ opb;
            fu_pkg::ALU_SLT:  result = {31'b0, opa_s < opb_s};
            fu_pkg::ALU_SLTU: result = {31'b0, opa < opb};
            fu_pkg::ALU_SLL:  result = opa << opb[4:0];
            fu_pkg::ALU_SRL:  result = opa >> opb[4:0];
            fu_pkg::ALU_SRA:  result = opa_s >>> opb[4:0];
            default:          result = fu_pkg::ALU_BAD;
        endcase
    end

    // branch compare uses rs1 and rs2, never the muxed operands
    always_comb begin
        case (inst[14:12])
            3'b000:  cmp_true = op1 == op2;     // beq
            3'b001:  cmp_true = op1 != op2;     // bne
            3'b100:  cmp_true = rs1_s < rs2_s;  // blt
            3'b101:  cmp_true = rs1_s >= rs2_s; // bge
            3'b110:  cmp_true = op1 < op2;      // bltu
            3'b111:  cmp_true = op1 >= op2;     // bgeu
            default: cmp_true = 1'b0;
        endcase
    end

    assign take_branch = uncond_branch || (cond_branch && cmp_true);
    assign done        = valid;
    assign tag_out     = tag;

endmodule

`default_nettype wire

/* mult_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module mult_ctrl (
    input  wire logic clock,
    input  wire logic arst_n,
    input  wire logic start,
    input  wire logic avail,
    output logic      busy,
    output logic      done,
    mult_step_if.ctrl step_if
);

    typedef enum logic [1:0] {
        IDLE = 2'h0,
        RUN  = 2'h1,
        FIN  = 2'h2,
        DONE = 2'h3
    } state_t;

    state_t state_q, state_d;
    logic   load_q; // first RUN cycle is the load cycle

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (start) state_d = RUN;
            RUN:     if (step_if.step && step_if.last) state_d = FIN;
            FIN:     state_d = DONE;
            DONE:    if (avail) state_d = IDLE; // held until the bus takes it
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= IDLE;
            load_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            load_q  <= (state_q == IDLE) && start;
        end
    end

    assign step_if.load   = load_q;
    assign step_if.step   = (state_q == RUN) && !load_q;
    assign step_if.finish = (state_q == FIN);

    assign busy = (state_q != IDLE);
    assign done = (state_q == DONE);

    // counter may only flag its final count during a step
    a_last_in_step: assert property (@(posedge clock) disable iff (!arst_n)
        step_if.last |-> step_if.step);

endmodule

`default_nettype wire

/* mult_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module mult_counter #(
    parameter int STEP_BITS = 4
) (
    input wire logic     clock,
    input wire logic     arst_n,
    mult_step_if.counter step_if
);

    localparam int STEPS = 32 / STEP_BITS;
    localparam int CNT_W = (STEPS > 1) ? $clog2(STEPS) : 1;
    localparam int LIMIT = STEPS - 1;

    logic [CNT_W-1:0] count_q;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            count_q <= '0;
        end else if (step_if.load || (step_if.step && step_if.last)) begin
            count_q <= '0; // fresh count per multiply
        end else if (step_if.step) begin
            count_q <= count_q + 1'b1;
        end
    end

    assign step_if.last = (count_q == CNT_W'(LIMIT));

    // count rests at zero outside step cycles
    a_count_idle: assert property (@(posedge clock) disable iff (!arst_n)
        !step_if.step |-> (count_q == '0));

endmodule

`default_nettype wire

/* mult_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module mult_datapath #(
    parameter int  STEP_BITS = 4,
    parameter type TAG_T     = fu_pkg::fu_tag_t
) (
    input  wire logic               clock,
    input  wire logic               arst_n,
    input  wire fu_pkg::data_t      op1,
    input  wire fu_pkg::data_t      op2,
    input  wire fu_pkg::mult_func_t func,
    input  wire TAG_T               tag,
    output fu_pkg::data_t           result,
    output TAG_T                    tag_out,
    mult_step_if.datapath           step_if
);

    // request captured on the start edge and loaded a cycle later
    fu_pkg::data_t      in_op1_q, in_op2_q;
    fu_pkg::mult_func_t in_func_q, func_q;
    TAG_T               in_tag_q, tag_q;

    logic               a_neg, b_neg, neg_q;
    fu_pkg::data_t      abs_a, abs_b, result_q;
    logic [63:0]        mcand_q, acc_q, partial, product;
    logic [31:0]        mplier_q;

    assign a_neg = in_op1_q[31] && (in_func_q != fu_pkg::MULT_MULHU);
    assign b_neg = in_op2_q[31] && (in_func_q inside {fu_pkg::MULT_MUL, fu_pkg::MULT_MULH});
    assign abs_a = a_neg ? -in_op1_q : in_op1_q;
    assign abs_b = b_neg ? -in_op2_q : in_op2_q;

    assign partial = mcand_q * 64'(mplier_q[STEP_BITS-1:0]); // one digit
    assign product = neg_q ? -acc_q : acc_q;

    always_ff @(posedge clock) begin
        in_op1_q  <= op1;
        in_op2_q  <= op2;
        in_func_q <= func;
        in_tag_q  <= tag;
        if (step_if.load) begin
            mcand_q  <= {32'b0, abs_a};
            mplier_q <= abs_b;
            acc_q    <= '0;
            neg_q    <= a_neg ^ b_neg;
            func_q   <= in_func_q;
            tag_q    <= in_tag_q;
        end else if (step_if.step) begin
            acc_q    <= acc_q + partial;
            mcand_q  <= mcand_q << STEP_BITS;
            mplier_q <= mplier_q >> STEP_BITS;
        end
        if (step_if.finish) begin
            result_q <= (func_q == fu_pkg::MULT_MUL) ? product[31:0] : product[63:32];
        end
    end

    assign result  = result_q;
    assign tag_out = tag_q;

    a_result_known: assert property (@(posedge clock) disable iff (!arst_n)
        step_if.finish |=> !$isunknown(result));

endmodule

`default_nettype wire

/* fu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fu_top #(
    parameter int STEP_BITS = 4 // 1, 2, 4 or 8
) (
    input  wire logic               clock,
    input  wire logic               arst_n,

    input  wire logic               alu_valid,
    input  wire fu_pkg::inst_t      alu_inst,
    input  wire fu_pkg::data_t      alu_pc,
    input  wire fu_pkg::data_t      alu_op1,
    input  wire fu_pkg::data_t      alu_op2,
    input  wire fu_pkg::alu_func_t  alu_func,
    input  wire fu_pkg::opa_sel_t   alu_opa_sel,
    input  wire fu_pkg::opb_sel_t   alu_opb_sel,
    input  wire logic               alu_cond_branch,
    input  wire logic               alu_uncond_branch,
    input  wire fu_pkg::robn_t      alu_robn,
    input  wire fu_pkg::prn_t       alu_prn,
    output logic                    alu_done,
    output fu_pkg::data_t           alu_result,
    output logic                    alu_take_branch,
    output fu_pkg::robn_t           alu_robn_out,
    output fu_pkg::prn_t            alu_prn_out,

    input  wire logic               mult_start,
    input  wire fu_pkg::data_t      mult_op1,
    input  wire fu_pkg::data_t      mult_op2,
    input  wire fu_pkg::mult_func_t mult_func,
    input  wire fu_pkg::robn_t      mult_robn,
    input  wire fu_pkg::prn_t       mult_prn,
    input  wire logic               mult_avail,
    output logic                    mult_busy,
    output logic                    mult_done,
    output fu_pkg::data_t           mult_result,
    output fu_pkg::robn_t           mult_robn_out,
    output fu_pkg::prn_t            mult_prn_out
);

    fu_pkg::fu_tag_t alu_tag, alu_tag_out, mult_tag, mult_tag_out;

    mult_step_if step_if ();

    assign alu_tag       = '{robn: alu_robn, prn: alu_prn};
    assign mult_tag      = '{robn: mult_robn, prn: mult_prn};
    assign alu_robn_out  = alu_tag_out.robn;
    assign alu_prn_out   = alu_tag_out.prn;
    assign mult_robn_out = mult_tag_out.robn;
    assign mult_prn_out  = mult_tag_out.prn;

    alu_unit alu_unit_i (
        .valid         (alu_valid),
        .inst          (alu_inst),
        .pc            (alu_pc),
        .op1           (alu_op1),
        .op2           (alu_op2),
        .func          (alu_func),
        .opa_sel       (alu_opa_sel),
        .opb_sel       (alu_opb_sel),
        .cond_branch   (alu_cond_branch),
        .uncond_branch (alu_uncond_branch),
        .tag           (alu_tag),
        .done          (alu_done),
        .result        (alu_result),
        .take_branch   (alu_take_branch),
        .tag_out       (alu_tag_out)
    );

    mult_ctrl mult_ctrl_i (
        .clock   (clock),
        .arst_n  (arst_n),
        .start   (mult_start),
        .avail   (mult_avail),
        .busy    (mult_busy),
        .done    (mult_done),
        .step_if (step_if.ctrl)
    );

    mult_counter #(
        .STEP_BITS (STEP_BITS)
    ) mult_counter_i (
        .clock   (clock),
        .arst_n  (arst_n),
        .step_if (step_if.counter)
    );

    mult_datapath #(
        .STEP_BITS (STEP_BITS),
        .TAG_T     (fu_pkg::fu_tag_t)
    ) mult_datapath_i (
        .clock   (clock),
        .arst_n  (arst_n),
        .op1     (mult_op1),
        .op2     (mult_op2),
        .func    (mult_func),
        .tag     (mult_tag),
        .result  (mult_result),
        .tag_out (mult_tag_out),
        .step_if (step_if.datapath)
    );

endmodule

`default_nettype wire

/* tb_fu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fu_top;

    localparam int STEP_BITS   = 4;
    localparam int MULT_LAT    = 32 / STEP_BITS + 2; // start edge to done high
    localparam int ALU_ROUNDS  = 8;
    localparam int MULT_ROUNDS = 6;
    localparam int BR_PAIRS    = 6;
    localparam int TIMEOUT_CYCLES = 4 + ALU_ROUNDS * 18 + BR_PAIRS * 8 * 3
        + (4 * (MULT_ROUNDS + 9) + 1) * (MULT_LAT + 3) + 4 * (MULT_LAT + 9) + 100;

    localparam fu_pkg::data_t CORNERS [3] = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000};
    // equal, less, greater, sign bit only, both ways, negative vs positive
    localparam fu_pkg::data_t BR_A [BR_PAIRS] = '{32'h0000_0005, 32'h0000_0003,
        32'h0000_0007, 32'h0000_0005, 32'h8000_0005, 32'hffff_fff0};
    localparam fu_pkg::data_t BR_B [BR_PAIRS] = '{32'h0000_0005, 32'h0000_0007,
        32'h0000_0003, 32'h8000_0005, 32'h0000_0005, 32'h0000_0010};

    logic               clock;
    logic               arst_n;
    logic               alu_valid;
    fu_pkg::inst_t      alu_inst;
    fu_pkg::data_t      alu_pc, alu_op1, alu_op2;
    fu_pkg::alu_func_t  alu_func;
    fu_pkg::opa_sel_t   alu_opa_sel;
    fu_pkg::opb_sel_t   alu_opb_sel;
    logic               alu_cond_branch, alu_uncond_branch;
    fu_pkg::robn_t      alu_robn, alu_robn_out;
    fu_pkg::prn_t       alu_prn, alu_prn_out;
    logic               alu_done, alu_take_branch;
    fu_pkg::data_t      alu_result;
    logic               mult_start, mult_avail, mult_busy, mult_done;
    fu_pkg::data_t      mult_op1, mult_op2, mult_result;
    fu_pkg::mult_func_t mult_func;
    fu_pkg::robn_t      mult_robn, mult_robn_out;
    fu_pkg::prn_t       mult_prn, mult_prn_out;

    logic [31:0] lfsr_q = 32'h86b1_5c07;
    int          errors = 0;
    int          checks = 0;
    int          cycle_count = 0;

    fu_top #(
        .STEP_BITS (STEP_BITS)
    ) fu_top_i (
        .clock (clock), .arst_n (arst_n),
        .alu_valid (alu_valid), .alu_inst (alu_inst), .alu_pc (alu_pc),
        .alu_op1 (alu_op1), .alu_op2 (alu_op2), .alu_func (alu_func),
        .alu_opa_sel (alu_opa_sel), .alu_opb_sel (alu_opb_sel),
        .alu_cond_branch (alu_cond_branch), .alu_uncond_branch (alu_uncond_branch),
        .alu_robn (alu_robn), .alu_prn (alu_prn),
        .alu_done (alu_done), .alu_result (alu_result), .alu_take_branch (alu_take_branch),
        .alu_robn_out (alu_robn_out), .alu_prn_out (alu_prn_out),
        .mult_start (mult_start), .mult_op1 (mult_op1), .mult_op2 (mult_op2),
        .mult_func (mult_func), .mult_robn (mult_robn), .mult_prn (mult_prn),
        .mult_avail (mult_avail), .mult_busy (mult_busy), .mult_done (mult_done),
        .mult_result (mult_result), .mult_robn_out (mult_robn_out),
        .mult_prn_out (mult_prn_out)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR @%0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    function automatic fu_pkg::data_t alu_model(input fu_pkg::alu_func_t f,
                                                input fu_pkg::data_t a, input fu_pkg::data_t b);
        case (f)
            fu_pkg::ALU_ADD:  return a + b;
            fu_pkg::ALU_SUB:  return a - b;
            fu_pkg::ALU_AND:  return a & b;
            fu_pkg::ALU_OR:   return a | b;
            fu_pkg::ALU_XOR:  return a ^ b;
            fu_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            fu_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            fu_pkg::ALU_SLL:  return a << b[4:0];
            fu_pkg::ALU_SRL:  return a >> b[4:0];
            fu_pkg::ALU_SRA:  return $signed(a) >>> b[4:0];
            default:          return fu_pkg::ALU_BAD;
        endcase
    endfunction

    function automatic logic branch_model(input logic [2:0] f3, input fu_pkg::data_t a,
                                          input fu_pkg::data_t b, input logic cond,
                                          input logic uncond);
        logic cmp;
        case (f3)
            3'b000:  cmp = (a == b);
            3'b001:  cmp = (a != b);
            3'b100:  cmp = ($signed(a) < $signed(b));
            3'b101:  cmp = ($signed(a) >= $signed(b));
            3'b110:  cmp = (a < b);
            3'b111:  cmp = (a >= b);
            default: cmp = 1'b0; // not a branch
        endcase
        return uncond | (cond & cmp);
    endfunction

    // full 64-bit product of the extended operands
    function automatic fu_pkg::data_t mult_model(input fu_pkg::mult_func_t f,
                                                 input fu_pkg::data_t a, input fu_pkg::data_t b);
        logic [63:0] ea, eb, prod;
        ea = (f == fu_pkg::MULT_MULHU) ? {32'b0, a} : {{32{a[31]}}, a};
        eb = (f == fu_pkg::MULT_MULHSU || f == fu_pkg::MULT_MULHU) ? {32'b0, b}
                                                                   : {{32{b[31]}}, b};
        prod = ea * eb;
        return (f == fu_pkg::MULT_MUL) ? prod[31:0] : prod[63:32];
    endfunction

    task automatic apply_alu_op(input string what, input fu_pkg::alu_func_t f,
                                input fu_pkg::opa_sel_t sa, input fu_pkg::opb_sel_t sb,
                                input fu_pkg::inst_t inst, input fu_pkg::data_t a,
                                input fu_pkg::data_t b, input fu_pkg::data_t pc,
                                input fu_pkg::data_t exp);
        logic [31:0] r;
        rand_bits(11, r);
        alu_valid         = 1'b1;
        alu_func          = f;
        alu_opa_sel       = sa;
        alu_opb_sel       = sb;
        alu_inst          = inst;
        alu_op1           = a;
        alu_op2           = b;
        alu_pc            = pc;
        alu_cond_branch   = 1'b0;
        alu_uncond_branch = 1'b0;
        alu_robn          = r[10:6];
        alu_prn           = r[5:0];
        @(posedge clock); // combinational result checked in the same cycle
        check_val({what, " done"}, 32'(alu_done), 32'd1);
        check_val(what, alu_result, exp);
        check_val({what, " robn"}, 32'(alu_robn_out), 32'(r[10:6]));
        check_val({what, " prn"}, 32'(alu_prn_out), 32'(r[5:0]));
        @(negedge clock);
    endtask

    task automatic check_branch(input logic [2:0] f3, input fu_pkg::data_t a,
                                input fu_pkg::data_t b, input logic cond, input logic uncond);
        logic [31:0] r;
        logic        exp;
        rand_bits(32, r);
        exp               = branch_model(f3, a, b, cond, uncond);
        alu_valid         = 1'b1;
        alu_inst          = {r[31:15], f3, r[11:0]};
        alu_op1           = a;
        alu_op2           = b;
        alu_func          = fu_pkg::ALU_ADD;
        alu_opa_sel       = fu_pkg::OPA_IS_RS1;
        alu_opb_sel       = fu_pkg::OPB_IS_RS2;
        alu_cond_branch   = cond;
        alu_uncond_branch = uncond;
        @(posedge clock);
        check_val($sformatf("take_branch f3=%0d a=%h b=%h c=%0b u=%0b", f3, a, b, cond, uncond),
                  32'(alu_take_branch), 32'(exp));
        @(negedge clock);
    endtask

    // hold > 0 keeps avail low that many cycles and pulses start while busy
    task automatic run_multiply(input fu_pkg::mult_func_t f, input fu_pkg::data_t a,
                                input fu_pkg::data_t b, input int hold);
        fu_pkg::data_t exp;
        logic [31:0]   r;
        fu_pkg::robn_t rn;
        fu_pkg::prn_t  pn;
        int            lat;
        exp = mult_model(f, a, b);
        rand_bits(11, r);
        rn = r[10:6];
        pn = r[5:0];
        check_val("busy before start", 32'(mult_busy), 32'd0);
        mult_start = 1'b1;
        mult_op1   = a;
        mult_op2   = b;
        mult_func  = f;
        mult_robn  = rn;
        mult_prn   = pn;
        mult_avail = (hold == 0);
        @(posedge clock);
        @(negedge clock);
        rand_bits(32, r);
        mult_op1   = r; // request only valid with start
        mult_op2   = ~r;
        mult_func  = fu_pkg::mult_func_t'(~f);
        mult_robn  = ~rn;
        mult_prn   = ~pn;
        mult_start = (hold > 0);
        check_val("busy after start", 32'(mult_busy), 32'd1);
        lat = 0;
        while (!mult_done && lat < 4 * MULT_LAT) begin
            @(posedge clock);
            lat++;
            @(negedge clock);
            mult_start = 1'b0;
        end
        check_val($sformatf("mult latency %s", f.name()), lat, MULT_LAT);
        check_val($sformatf("%s %h x %h", f.name(), a, b), mult_result, exp);
        check_val("mult robn", 32'(mult_robn_out), 32'(rn));
        check_val("mult prn", 32'(mult_prn_out), 32'(pn));
        for (int i = 0; i < hold; i++) begin
            mult_start = (i == 0);
            @(posedge clock);
            @(negedge clock);
            mult_start = 1'b0;
            check_val("done held", 32'(mult_done), 32'd1);
            check_val("busy held", 32'(mult_busy), 32'd1);
            check_val("result held", mult_result, exp);
            check_val("robn held", 32'(mult_robn_out), 32'(rn));
            check_val("prn held", 32'(mult_prn_out), 32'(pn));
        end
        mult_avail = 1'b1;
        @(posedge clock); // result bus takes it
        @(negedge clock);
        mult_avail = 1'b0;
        check_val("done after accept", 32'(mult_done), 32'd0);
        check_val("busy after accept", 32'(mult_busy), 32'd0);
    endtask

    task automatic alu_function_sweep();
        fu_pkg::data_t     a, b;
        fu_pkg::alu_func_t f;
        for (int k = 0; k < ALU_ROUNDS; k++) begin
            for (int i = 0; i < 10; i++) begin
                rand_bits(32, a);
                rand_bits(32, b);
                f = fu_pkg::alu_func_t'(i);
                apply_alu_op(f.name(), f, fu_pkg::OPA_IS_RS1, fu_pkg::OPB_IS_RS2, '0, a, b, '0,
                             alu_model(f, a, b));
            end
        end
        alu_valid = 1'b0;
        @(posedge clock);
        check_val("done without valid", 32'(alu_done), 32'd0);
        @(negedge clock);
    endtask

    // immediates are encoded into the fields, then expected back sign-extended
    task automatic operand_select_sweep();
        fu_pkg::data_t a, b, pc, imm, base;
        for (int k = 0; k < ALU_ROUNDS; k++) begin
            rand_bits(32, a);
            rand_bits(32, b);
            rand_bits(32, pc);
            rand_bits(32, imm);
            rand_bits(32, base);
            apply_alu_op("opa pc", fu_pkg::ALU_ADD, fu_pkg::OPA_IS_PC, fu_pkg::OPB_IS_RS2,
                         base, a, b, pc, pc + b);
            apply_alu_op("opa zero", fu_pkg::ALU_ADD, fu_pkg::OPA_IS_ZERO, fu_pkg::OPB_IS_RS2,
                         base, a, b, pc, b);
            apply_alu_op("i-imm", fu_pkg::ALU_ADD, fu_pkg::OPA_IS_RS1, fu_pkg::OPB_IS_I_IMM,
                         {imm[11:0], base[19:0]}, a, b, pc, a + {{20{imm[11]}}, imm[11:0]});
            apply_alu_op("s-imm", fu_pkg::ALU_ADD, fu_pkg::OPA_IS_RS1, fu_pkg::OPB_IS_S_IMM,
                         {imm[11:5], base[24:12], imm[4:0], base[6:0]}, a, b, pc,
                         a + {{20{imm[11]}}, imm[11:0]});
            apply_alu_op("b-imm", fu_pkg::ALU_ADD, fu_pkg::OPA_IS_RS1, fu_pkg::OPB_IS_B_IMM,
                         {imm[12], imm[10:5], base[24:12], imm[4:1], imm[11], base[6:0]},
                         a, b, pc, a + {{19{imm[12]}}, imm[12:1], 1'b0});
            apply_alu_op("u-imm", fu_pkg::ALU_ADD, fu_pkg::OPA_IS_RS1, fu_pkg::OPB_IS_U_IMM,
                         {imm[31:12], base[11:0]}, a, b, pc, a + {imm[31:12], 12'b0});
            apply_alu_op("j-imm", fu_pkg::ALU_ADD, fu_pkg::OPA_IS_RS1, fu_pkg::OPB_IS_J_IMM,
                         {imm[20], imm[10:1], imm[11], imm[19:12], base[11:0]}, a, b, pc,
                         a + {{11{imm[20]}}, imm[20:1], 1'b0});
        end
    endtask

    task automatic branch_sweep();
        for (int p = 0; p < BR_PAIRS; p++) begin
            for (int f3 = 0; f3 < 8; f3++) begin
                check_branch(3'(f3), BR_A[p], BR_B[p], 1'b1, 1'b0);
                check_branch(3'(f3), BR_A[p], BR_B[p], 1'b0, 1'b1);
                check_branch(3'(f3), BR_A[p], BR_B[p], 1'b0, 1'b0);
            end
        end
    endtask

    task automatic mult_sweep();
        fu_pkg::data_t      a, b;
        fu_pkg::mult_func_t f;
        for (int i = 0; i < 4; i++) begin
            f = fu_pkg::mult_func_t'(i);
            for (int k = 0; k < MULT_ROUNDS; k++) begin
                rand_bits(32, a);
                rand_bits(32, b);
                run_multiply(f, a, b, 0);
            end
            for (int x = 0; x < 3; x++) begin
                for (int y = 0; y < 3; y++) begin
                    run_multiply(f, CORNERS[x], CORNERS[y], 0);
                end
            end
        end
    endtask

    task automatic back_pressure_run();
        fu_pkg::data_t a, b;
        for (int i = 0; i < 4; i++) begin
            rand_bits(32, a);
            rand_bits(32, b);
            run_multiply(fu_pkg::mult_func_t'(i), a, b, 3 + i);
        end
        rand_bits(32, a);
        rand_bits(32, b);
        run_multiply(fu_pkg::MULT_MULH, a, b, 0); // next one after the ignored starts
    endtask

    initial begin
        arst_n            = 1'b0;
        alu_valid         = 1'b0;
        alu_inst          = '0;
        alu_pc            = '0;
        alu_op1           = '0;
        alu_op2           = '0;
        alu_func          = fu_pkg::ALU_ADD;
        alu_opa_sel       = fu_pkg::OPA_IS_RS1;
        alu_opb_sel       = fu_pkg::OPB_IS_RS2;
        alu_cond_branch   = 1'b0;
        alu_uncond_branch = 1'b0;
        alu_robn          = '0;
        alu_prn           = '0;
        mult_start        = 1'b0;
        mult_op1          = '0;
        mult_op2          = '0;
        mult_func         = fu_pkg::MULT_MUL;
        mult_robn         = '0;
        mult_prn          = '0;
        mult_avail        = 1'b0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
        check_val("busy out of reset", 32'(mult_busy), 32'd0);
        check_val("done out of reset", 32'(mult_done), 32'd0);
        alu_function_sweep();
        operand_select_sweep();
        branch_sweep();
        mult_sweep();
        back_pressure_run();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
fu_pkg.sv
mult_step_if.sv
alu_unit.sv
mult_ctrl.sv
mult_counter.sv
mult_datapath.sv
fu_top.sv
tb_fu_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fu_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= >>> FAIL

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@if grep -q -- '$(FAIL_MSG)' $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
